// ==== common/gyro_pkg.sv ====
`default_nettype none

package gyro_pkg;

	// converter and loop word widths
	localparam int ADC_W  = 14;
	localparam int DAC_W  = 16;
	localparam int DATA_W = 32;

	// averaging window is 2**shift samples
	// 14-bit samples times 2**10 still fit the 32-bit accumulator
	localparam int MAX_AVG_SHIFT = 10;

	// signed loop word
	// used for amplitude, error, step and offset
	typedef logic signed [DATA_W-1:0] data_t;

	// raw adc sample, two's complement
	typedef logic signed [ADC_W-1:0] adc_t;

	// dac code, wraps modulo 2**16
	typedef logic [DAC_W-1:0] dac_t;

	// half period and settling counts in clock cycles
	typedef logic [31:0] cnt_t;

	// right shift for gains and averaging
	typedef logic [4:0] shift_t;

endpackage

`default_nettype wire

// ==== common/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

	// axi4-lite bus widths
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;

	typedef logic [AXI_ADDR_W-1:0] axil_addr_t;
	typedef logic [AXI_DATA_W-1:0] axil_data_t;

	// byte offsets of the 32-bit words
	// modulation settings
	localparam axil_addr_t REG_FREQ_CNT   = 8'h00;
	localparam axil_addr_t REG_AMP_H      = 8'h04;
	localparam axil_addr_t REG_AMP_L      = 8'h08;
	// demodulator settings
	localparam axil_addr_t REG_POLARITY   = 8'h0C;
	localparam axil_addr_t REG_WAIT_CNT   = 8'h10;
	localparam axil_addr_t REG_AVG_SEL    = 8'h14;
	// step and ramp settings
	localparam axil_addr_t REG_GAIN_STEP  = 8'h18;
	localparam axil_addr_t REG_CONST_STEP = 8'h1C;
	localparam axil_addr_t REG_FB_ON      = 8'h20;
	localparam axil_addr_t REG_GAIN_RAMP  = 8'h24;
	localparam axil_addr_t REG_ERR_OFFSET = 8'h28;
	// readback, writes ignored
	localparam axil_addr_t REG_ERR        = 8'h30;
	localparam axil_addr_t REG_STEP       = 8'h34;

	// okay response
	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== dv/tb_fog_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fog_loop;

	import gyro_pkg::*;
	import regmap_pkg::*;

	// half periods of each test, also sizing the watchdog
	localparam int N_MOD  = 24;
	localparam int N_ERR  = 40;
	localparam int N_RAMP = 32;
	localparam int N_FB   = 40;
	localparam int WATCHDOG_CYCLES =
		3 * (13 * N_MOD + 16 * N_ERR + 14 * N_RAMP + 18 * N_FB) + 1000;

	// plant levels and loop settings
	localparam adc_t       A_HI       = 14'sd3000;
	localparam adc_t       A_LO       = -14'sd1500;
	localparam data_t      OFFSET     = -32'sd37;
	localparam data_t      K_STEP     = -32'sd2000001;
	localparam int         RAMP_SHIFT = 3;
	localparam data_t      E_FB       = -32'sd1200;
	localparam int         FB_SHIFT   = 2;
	localparam axil_data_t STALL_WORD = 32'h5A5A_1234;

	logic       CLOCK_DAC_1;
	logic       i_rst_n;
	axil_addr_t i_awaddr;
	logic       i_awvalid;
	logic       o_awready;
	axil_data_t i_wdata;
	logic       i_wvalid;
	logic       o_wready;
	logic [1:0] o_bresp;
	logic       o_bvalid;
	logic       i_bready;
	axil_addr_t i_araddr;
	logic       i_arvalid;
	logic       o_arready;
	axil_data_t o_rdata;
	logic [1:0] o_rresp;
	logic       o_rvalid;
	logic       i_rready;
	adc_t       i_adc;
	dac_t       o_dac;

	integer seed;
	int     errors;
	int     err_base;
	int     tests_run;
	int     tests_failed;
	string  cur_test;
	data_t  amp_h;
	data_t  amp_l;
	// plant state
	dac_t   plant_amp;
	adc_t   adc_hi;
	adc_t   adc_lo;
	logic   dac_match;

	fog_loop_top DUT (.*);

	initial begin
		CLOCK_DAC_1 = 1'b0;
		forever #5 CLOCK_DAC_1 = ~CLOCK_DAC_1;
	end

	// detector stand-in, high level only on the high modulation code
	always @(negedge CLOCK_DAC_1) begin
		dac_match = (o_dac == plant_amp);
	end

	always @(posedge CLOCK_DAC_1) begin
		i_adc <= dac_match ? adc_hi : adc_lo;
	end

	task automatic open_test(input string name);
		cur_test = name;
		err_base = errors;
	endtask

	task automatic close_test;
		tests_run++;
		if (errors == err_base) begin
			$display("test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errors - err_base);
		end
	endtask

	task automatic compare_data(input string label, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("[FAIL] %s %s expected %0d (0x%08h) actual %0d (0x%08h)",
				cur_test, label, exp, exp, act, act);
			errors++;
		end
	endtask

	task automatic compare_dac(input string label, input dac_t exp, input dac_t act);
		if (exp !== act) begin
			$display("[FAIL] %s %s expected 0x%04h actual 0x%04h", cur_test, label, exp, act);
			errors++;
		end
	endtask

	task automatic compare_resp(input string label, input logic [1:0] exp,
		input logic [1:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s expected %0d actual %0d", cur_test, label, exp, act);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("error in %s: %s", cur_test, msg);
		errors++;
	endtask

	task automatic reset_dut;
		@(posedge CLOCK_DAC_1);
		i_rst_n <= 1'b0;
		repeat (5) @(posedge CLOCK_DAC_1);
		i_rst_n <= 1'b1;
	endtask

	// address and data raised together, each dropped after its own beat
	task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
		logic aw_fire;
		logic w_fire;
		logic aw_done;
		logic w_done;
		@(posedge CLOCK_DAC_1);
		i_awaddr  <= addr;
		i_awvalid <= 1'b1;
		i_wdata   <= data;
		i_wvalid  <= 1'b1;
		aw_done = 1'b0;
		w_done  = 1'b0;
		while (!(aw_done && w_done)) begin
			// ready seen mid-cycle, beat lands on the next edge
			@(negedge CLOCK_DAC_1);
			aw_fire = i_awvalid && o_awready;
			w_fire  = i_wvalid && o_wready;
			@(posedge CLOCK_DAC_1);
			if (aw_fire) begin
				i_awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire) begin
				i_wvalid <= 1'b0;
				w_done = 1'b1;
			end
		end
		@(negedge CLOCK_DAC_1);
		while (!o_bvalid) @(negedge CLOCK_DAC_1);
		compare_resp("write response", RESP_OKAY, o_bresp);
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
		logic fire;
		@(posedge CLOCK_DAC_1);
		i_araddr  <= addr;
		i_arvalid <= 1'b1;
		fire = 1'b0;
		while (!fire) begin
			@(negedge CLOCK_DAC_1);
			fire = o_arready;
			@(posedge CLOCK_DAC_1);
		end
		i_arvalid <= 1'b0;
		@(negedge CLOCK_DAC_1);
		while (!o_rvalid) @(negedge CLOCK_DAC_1);
		compare_resp("read response", RESP_OKAY, o_rresp);
		data = o_rdata;
	endtask

	task automatic register_access;
		axil_addr_t addrs[11];
		axil_data_t wvals[11];
		axil_data_t masks[11];
		axil_data_t rd;
		int         i;
		open_test("register_access");
		addrs = '{REG_FREQ_CNT, REG_AMP_H, REG_AMP_L, REG_POLARITY, REG_WAIT_CNT,
			REG_AVG_SEL, REG_GAIN_STEP, REG_CONST_STEP, REG_FB_ON, REG_GAIN_RAMP,
			REG_ERR_OFFSET};
		wvals = '{32'h0000_0123, axil_data_t'(amp_h), axil_data_t'(amp_l), 32'hFFFF_FFFF,
			32'h0000_0055, 32'h0000_0007, 32'h0000_0013, 32'h8765_4321, 32'h0000_0003,
			32'h0000_002A, 32'hDEAD_BEEF};
		// single bits and 5-bit shifts keep only their low bits
		masks = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF,
			32'h0000_001F, 32'h0000_001F, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_001F,
			32'hFFFF_FFFF};
		// all words through 0x34 clear, the hole at 0x2c too
		for (i = 0; i < 14; i++) begin
			axi_read(axil_addr_t'(4 * i), rd);
			compare_data($sformatf("reset word 0x%02h", 4 * i), '0, rd);
		end
		for (i = 0; i < 11; i++) begin
			axi_write(addrs[i], wvals[i]);
			axi_read(addrs[i], rd);
			compare_data($sformatf("word 0x%02h", addrs[i]), wvals[i] & masks[i], rd);
		end
		axi_write(8'h2C, 32'hFFFF_FFFF);
		axi_read(8'h2C, rd);
		compare_data("unmapped word", '0, rd);
		close_test();
	endtask

	task automatic modulation_square_wave;
		dac_t samples[$];
		int   run_len;
		int   runs;
		int   i;
		open_test("modulation_square_wave");
		reset_dut();
		axi_write(REG_FREQ_CNT, N_MOD);
		axi_write(REG_AMP_H, amp_h);
		axi_write(REG_AMP_L, amp_l);
		repeat (3 * N_MOD) @(posedge CLOCK_DAC_1);
		repeat (10 * N_MOD) begin
			@(negedge CLOCK_DAC_1);
			samples.push_back(o_dac);
		end
		run_len = 1;
		runs = 0;
		for (i = 1; i < samples.size(); i++) begin
			if (samples[i] != amp_h[15:0] && samples[i] != amp_l[15:0])
				note_failure($sformatf("o_dac 0x%04h is neither amplitude", samples[i]));
			if (samples[i] == samples[i-1]) begin
				run_len++;
			end else begin
				// first run starts mid-half, last one is cut off
				if (runs > 0)
					compare_data("run length", data_t'(N_MOD), data_t'(run_len));
				runs++;
				run_len = 1;
			end
		end
		if (runs < 4)
			note_failure("o_dac changed level too few times");
		close_test();
	endtask

	task automatic open_loop_error;
		axil_data_t rd;
		data_t      diff;
		open_test("open_loop_error");
		reset_dut();
		adc_hi = A_HI;
		adc_lo = A_LO;
		plant_amp = amp_h[15:0];
		diff = data_t'(A_HI) - data_t'(A_LO);
		axi_write(REG_FREQ_CNT, N_ERR);
		axi_write(REG_AMP_H, amp_h);
		axi_write(REG_AMP_L, amp_l);
		// settle past dac, plant and input register delays
		axi_write(REG_WAIT_CNT, 32'd6);
		axi_write(REG_AVG_SEL, 32'd3);
		axi_write(REG_ERR_OFFSET, OFFSET);
		repeat (8 * N_ERR) @(posedge CLOCK_DAC_1);
		axi_read(REG_ERR, rd);
		compare_data("error polarity 0", diff + OFFSET, rd);
		axi_write(REG_POLARITY, 32'd1);
		repeat (8 * N_ERR) @(posedge CLOCK_DAC_1);
		axi_read(REG_ERR, rd);
		compare_data("error polarity 1", OFFSET - diff, rd);
		close_test();
	endtask

	task automatic constant_step_ramp;
		axil_data_t rd;
		data_t      scaled;
		dac_t       delta;
		dac_t       prev;
		int         changes;
		int         cycles;
		open_test("constant_step_ramp");
		reset_dut();
		scaled = K_STEP >>> RAMP_SHIFT;
		delta = scaled[15:0];
		// equal amplitudes, so every half start moves by the ramp alone
		axi_write(REG_FREQ_CNT, N_RAMP);
		axi_write(REG_AMP_H, amp_h);
		axi_write(REG_AMP_L, amp_h);
		axi_write(REG_GAIN_RAMP, RAMP_SHIFT);
		axi_write(REG_CONST_STEP, K_STEP);
		repeat (6 * N_RAMP) @(posedge CLOCK_DAC_1);
		axi_read(REG_STEP, rd);
		compare_data("constant step", K_STEP, rd);
		@(negedge CLOCK_DAC_1);
		prev = o_dac;
		changes = 0;
		cycles = 0;
		while (changes < 6 && cycles < 8 * N_RAMP) begin
			@(negedge CLOCK_DAC_1);
			cycles++;
			if (o_dac != prev) begin
				compare_dac("half start", prev + delta, o_dac);
				prev = o_dac;
				changes++;
			end
		end
		if (changes < 6)
			note_failure("o_dac stopped stepping with a nonzero step");
		close_test();
	endtask

	task automatic closed_loop_step;
		axil_data_t rd;
		data_t      step1;
		data_t      step2;
		data_t      se;
		open_test("closed_loop_step");
		reset_dut();
		// equal levels, the error is the offset alone
		adc_hi = A_HI;
		adc_lo = A_HI;
		se = E_FB >>> FB_SHIFT;
		axi_write(REG_FREQ_CNT, N_FB);
		axi_write(REG_ERR_OFFSET, E_FB);
		axi_write(REG_GAIN_STEP, FB_SHIFT);
		// both half averages valid before integrating
		repeat (6 * N_FB) @(posedge CLOCK_DAC_1);
		axi_write(REG_FB_ON, 32'd1);
		repeat (4 * N_FB) @(posedge CLOCK_DAC_1);
		axi_read(REG_STEP, rd);
		step1 = rd;
		repeat (8 * N_FB) @(posedge CLOCK_DAC_1);
		axi_read(REG_STEP, rd);
		step2 = rd;
		if (step1 == 0)
			note_failure("step did not move with feedback on");
		compare_data("first step remainder", '0, step1 % se);
		compare_data("second step remainder", '0, step2 % se);
		if ((step1 < 0) != (se < 0))
			note_failure("step sign differs from the error sign");
		if ((step2 < 0 ? -step2 : step2) <= (step1 < 0 ? -step1 : step1))
			note_failure("step did not grow between reads");
		close_test();
	endtask

	task automatic response_stall;
		axil_data_t held;
		int         i;
		open_test("response_stall");
		@(posedge CLOCK_DAC_1);
		i_bready <= 1'b0;
		i_rready <= 1'b0;
		axi_write(REG_CONST_STEP, STALL_WORD);
		for (i = 0; i < 20; i++) begin
			@(negedge CLOCK_DAC_1);
			if (!o_bvalid)
				note_failure($sformatf("bvalid dropped at stall cycle %0d", i));
			if (o_awready || o_wready)
				note_failure($sformatf("write ready high with a response pending at cycle %0d",
					i));
		end
		@(posedge CLOCK_DAC_1);
		i_bready <= 1'b1;
		axi_read(REG_CONST_STEP, held);
		compare_data("stalled read", STALL_WORD, held);
		// register behind the stalled beat changes under it
		axi_write(REG_CONST_STEP, ~STALL_WORD);
		for (i = 0; i < 20; i++) begin
			@(negedge CLOCK_DAC_1);
			if (!o_rvalid)
				note_failure($sformatf("rvalid dropped at stall cycle %0d", i));
			if (o_arready)
				note_failure($sformatf("arready high with a read pending at cycle %0d", i));
			compare_data("rdata hold", held, o_rdata);
		end
		@(posedge CLOCK_DAC_1);
		i_rready <= 1'b1;
		@(posedge CLOCK_DAC_1);
		@(negedge CLOCK_DAC_1);
		if (o_rvalid || o_bvalid)
			note_failure("a response stayed valid after its ready");
		close_test();
	endtask

	initial begin
		seed = 32'hfff4762b;
		errors = 0;
		err_base = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = "reset";
		i_rst_n   <= 1'b0;
		i_awaddr  <= '0;
		i_awvalid <= 1'b0;
		i_wdata   <= '0;
		i_wvalid  <= 1'b0;
		i_bready  <= 1'b1;
		i_araddr  <= '0;
		i_arvalid <= 1'b0;
		i_rready  <= 1'b1;
		i_adc     <= '0;
		adc_hi = A_HI;
		adc_lo = A_LO;
		plant_amp = '0;
		dac_match = 1'b0;
		// amplitudes must differ in the dac bits
		amp_h = $random(seed);
		amp_l = $random(seed);
		if (amp_l[15:0] == amp_h[15:0])
			amp_l[15:0] = ~amp_h[15:0];
		repeat (5) @(posedge CLOCK_DAC_1);
		i_rst_n <= 1'b1;
		register_access();
		modulation_square_wave();
		open_loop_error();
		constant_step_ramp();
		closed_loop_step();
		response_stall();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// bound from the summed half periods of all tests
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_DAC_1);
		$display("timeout in %s after %0d cycles", cur_test, WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
common/gyro_pkg.sv
common/regmap_pkg.sv
loop/mod_gen.sv
loop/err_demod.sv
loop/fb_step_gen.sv
loop/phase_ramp_gen.sv
source/axil_regs.sv
source/fog_loop_top.sv
dv/tb_fog_loop.sv

// ==== loop/err_demod.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_demod (
	input  logic             CLOCK_DAC_1,
	input  logic             i_rst_n,
	input  logic             i_mod_high,
	input  logic             i_mod_trig,
	input  gyro_pkg::adc_t   i_adc,
	input  gyro_pkg::cnt_t   i_wait_cnt,
	input  gyro_pkg::shift_t i_avg_sel,
	input  logic             i_polarity,
	input  gyro_pkg::data_t  i_err_offset,
	output gyro_pkg::data_t  o_err,
	output logic             o_err_valid
);

	import gyro_pkg::*;

	// settle, accumulate, then idle until the next switch
	typedef enum logic [1:0] {WAIT, SUM, HOLD} state_t;

	state_t state;
	adc_t   adc_q;
	cnt_t   cnt;
	cnt_t   sum_last;
	// level of the half under measurement
	logic   half_high;
	data_t  acc;
	data_t  acc_next;
	data_t  high_avg;
	data_t  low_avg;
	data_t  diff;
	logic   high_done;
	logic   err_load;

	// window of 2**avg_sel samples, minus one
	assign sum_last = (cnt_t'(1) << i_avg_sel) - 1'b1;
	assign acc_next = acc + data_t'(adc_q);

	// high half finished its average before the switch
	assign high_done = (state == HOLD) && half_high;
	// switch into low ends a high half, one error per period
	assign err_load  = i_mod_trig && !i_mod_high && high_done;
	assign diff      = high_avg - low_avg;

	// one input stage, sample already on this clock
	always_ff @(posedge CLOCK_DAC_1) begin
		adc_q <= i_adc;
	end

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			state     <= HOLD;
			cnt       <= '0;
			half_high <= 1'b0;
			acc       <= '0;
			high_avg  <= '0;
			low_avg   <= '0;
		end else if (i_mod_trig) begin
			// every switch restarts the measurement
			half_high <= i_mod_high;
			cnt       <= '0;
			acc       <= '0;
			state     <= (i_wait_cnt == '0) ? SUM : WAIT;
		end else begin
			case (state)
				WAIT: begin
					// modulator transient settling
					if (cnt >= i_wait_cnt - 1'b1) begin
						cnt   <= '0;
						state <= SUM;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				SUM: begin
					acc <= acc_next;
					if (cnt >= sum_last) begin
						state <= HOLD;
						// arithmetic shift keeps the sign
						if (half_high)
							high_avg <= acc_next >>> i_avg_sel;
						else
							low_avg <= acc_next >>> i_avg_sel;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= HOLD;
			endcase
		end
	end

	// error register, valid the cycle after the switch
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			o_err       <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= err_load;
			if (err_load)
				o_err <= (i_polarity ? -diff : diff) + i_err_offset;
		end
	end

	// host setting must leave accumulator headroom
	a_avg_sel_range: assert property (@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		i_avg_sel <= MAX_AVG_SHIFT);

endmodule

`default_nettype wire

// ==== loop/fb_step_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_step_gen (
	input  logic             CLOCK_DAC_1,
	input  logic             i_rst_n,
	input  gyro_pkg::data_t  i_err,
	input  logic             i_err_valid,
	input  logic             i_fb_on,
	input  gyro_pkg::shift_t i_gain_step,
	input  gyro_pkg::data_t  i_const_step,
	output gyro_pkg::data_t  o_step
);

	import gyro_pkg::*;

	// error after loop gain
	data_t err_scaled;

	assign err_scaled = i_err >>> i_gain_step;

	// integrate once per period
	// open loop holds the host step instead
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			o_step <= '0;
		end else if (i_err_valid) begin
			if (i_fb_on)
				o_step <= o_step + err_scaled;
			else
				o_step <= i_const_step;
		end
	end

endmodule

`default_nettype wire

// ==== loop/mod_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mod_gen (
	input  logic            CLOCK_DAC_1,
	input  logic            i_rst_n,
	input  gyro_pkg::cnt_t  i_freq_cnt,
	input  gyro_pkg::data_t i_amp_h,
	input  gyro_pkg::data_t i_amp_l,
	output gyro_pkg::data_t o_mod_out,
	output logic            o_mod_high,
	output logic            o_mod_trig
);

	import gyro_pkg::*;

	// position inside the running half
	cnt_t half_cnt;
	// length of the running half, taken at its switch
	cnt_t half_len;
	logic half_end;

	// last cycle of this half
	// a zero length (right after reset) switches every cycle
	assign half_end = (half_cnt + 1'b1) >= half_len;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			half_cnt   <= '0;
			half_len   <= '0;
			o_mod_high <= 1'b0;
			o_mod_trig <= 1'b0;
		end else if (half_end) begin
			// new half, new period from the register
			half_cnt   <= '0;
			half_len   <= i_freq_cnt;
			o_mod_high <= ~o_mod_high;
			o_mod_trig <= 1'b1;
		end else begin
			half_cnt   <= half_cnt + 1'b1;
			o_mod_trig <= 1'b0;
		end
	end

	// level select, amplitudes may change at any time
	assign o_mod_out = o_mod_high ? i_amp_h : i_amp_l;

endmodule

`default_nettype wire

// ==== loop/phase_ramp_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_ramp_gen (
	input  logic             CLOCK_DAC_1,
	input  logic             i_rst_n,
	input  gyro_pkg::data_t  i_step,
	input  gyro_pkg::data_t  i_mod_out,
	input  logic             i_mod_trig,
	input  gyro_pkg::shift_t i_gain_ramp,
	output gyro_pkg::dac_t   o_dac
);

	import gyro_pkg::*;

	// ramp increment after gain
	data_t step_scaled;
	// phase accumulator, wraps at full dac scale
	dac_t  ramp;
	dac_t  ramp_next;

	assign step_scaled = i_step >>> i_gain_ramp;

	// one step per half period
	assign ramp_next = i_mod_trig ? ramp + step_scaled[DAC_W-1:0] : ramp;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			ramp  <= '0;
			o_dac <= '0;
		end else begin
			ramp  <= ramp_next;
			// ramp and level change together, flat across the half
			o_dac <= ramp_next + i_mod_out[DAC_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_fog_loop -o sim_fog_loop
./obj_dir/sim_fog_loop > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== source/axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
	input  logic                   CLOCK_DAC_1,
	input  logic                   i_rst_n,
	input  regmap_pkg::axil_addr_t i_awaddr,
	input  logic                   i_awvalid,
	output logic                   o_awready,
	input  regmap_pkg::axil_data_t i_wdata,
	input  logic                   i_wvalid,
	output logic                   o_wready,
	output logic [1:0]             o_bresp,
	output logic                   o_bvalid,
	input  logic                   i_bready,
	input  regmap_pkg::axil_addr_t i_araddr,
	input  logic                   i_arvalid,
	output logic                   o_arready,
	output regmap_pkg::axil_data_t o_rdata,
	output logic [1:0]             o_rresp,
	output logic                   o_rvalid,
	input  logic                   i_rready,
	output gyro_pkg::cnt_t         o_freq_cnt,
	output gyro_pkg::cnt_t         o_wait_cnt,
	output gyro_pkg::data_t        o_amp_h,
	output gyro_pkg::data_t        o_amp_l,
	output gyro_pkg::data_t        o_const_step,
	output gyro_pkg::data_t        o_err_offset,
	output logic                   o_polarity,
	output logic                   o_fb_on,
	output gyro_pkg::shift_t       o_avg_sel,
	output gyro_pkg::shift_t       o_gain_step,
	output gyro_pkg::shift_t       o_gain_ramp,
	input  gyro_pkg::data_t        i_err,
	input  gyro_pkg::data_t        i_step
);

	import gyro_pkg::*;
	import regmap_pkg::*;

	// address and data may arrive on different cycles
	logic       aw_hold;
	logic       w_hold;
	axil_addr_t aw_addr_q;
	axil_data_t w_data_q;
	logic       aw_fire;
	logic       w_fire;
	logic       ar_fire;
	logic       wr_en;
	axil_addr_t wr_addr;
	axil_data_t wr_data;
	axil_addr_t wr_word;
	axil_addr_t rd_word;
	axil_data_t rd_mux;

	// one write outstanding, no new beats while the response waits
	assign o_awready = !aw_hold && !o_bvalid;
	assign o_wready  = !w_hold && !o_bvalid;
	// one read outstanding
	assign o_arready = !o_rvalid;
	assign o_bresp   = RESP_OKAY;
	assign o_rresp   = RESP_OKAY;

	assign aw_fire = i_awvalid && o_awready;
	assign w_fire  = i_wvalid && o_wready;
	assign ar_fire = i_arvalid && o_arready;

	// commit on the later of the two beats
	assign wr_en   = (aw_hold || aw_fire) && (w_hold || w_fire);
	assign wr_addr = aw_hold ? aw_addr_q : i_awaddr;
	assign wr_data = w_hold ? w_data_q : i_wdata;

	// word decode, low byte lanes dropped
	assign wr_word = {wr_addr[AXI_ADDR_W-1:2], 2'b00};
	assign rd_word = {i_araddr[AXI_ADDR_W-1:2], 2'b00};

	// write channel
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			aw_hold  <= 1'b0;
			w_hold   <= 1'b0;
			o_bvalid <= 1'b0;
		end else if (wr_en) begin
			aw_hold  <= 1'b0;
			w_hold   <= 1'b0;
			o_bvalid <= 1'b1;
		end else begin
			if (aw_fire)
				aw_hold <= 1'b1;
			if (w_fire)
				w_hold <= 1'b1;
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
		end
	end

	// parked beat payload
	always_ff @(posedge CLOCK_DAC_1) begin
		if (aw_fire)
			aw_addr_q <= i_awaddr;
		if (w_fire)
			w_data_q <= i_wdata;
	end

	// setting registers
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			o_freq_cnt   <= '0;
			o_wait_cnt   <= '0;
			o_amp_h      <= '0;
			o_amp_l      <= '0;
			o_const_step <= '0;
			o_err_offset <= '0;
			o_polarity   <= 1'b0;
			o_fb_on      <= 1'b0;
			o_avg_sel    <= '0;
			o_gain_step  <= '0;
			o_gain_ramp  <= '0;
		end else if (wr_en) begin
			case (wr_word)
				REG_FREQ_CNT:   o_freq_cnt   <= cnt_t'(wr_data);
				REG_AMP_H:      o_amp_h      <= data_t'(wr_data);
				REG_AMP_L:      o_amp_l      <= data_t'(wr_data);
				REG_POLARITY:   o_polarity   <= wr_data[0];
				REG_WAIT_CNT:   o_wait_cnt   <= cnt_t'(wr_data);
				REG_AVG_SEL:    o_avg_sel    <= shift_t'(wr_data);
				REG_GAIN_STEP:  o_gain_step  <= shift_t'(wr_data);
				REG_CONST_STEP: o_const_step <= data_t'(wr_data);
				REG_FB_ON:      o_fb_on      <= wr_data[0];
				REG_GAIN_RAMP:  o_gain_ramp  <= shift_t'(wr_data);
				REG_ERR_OFFSET: o_err_offset <= data_t'(wr_data);
				// readback and unmapped words keep nothing
				default: ;
			endcase
		end
	end

	// read decode, unmapped reads as zero
	always_comb begin
		case (rd_word)
			REG_FREQ_CNT:   rd_mux = axil_data_t'(o_freq_cnt);
			REG_AMP_H:      rd_mux = axil_data_t'(o_amp_h);
			REG_AMP_L:      rd_mux = axil_data_t'(o_amp_l);
			REG_POLARITY:   rd_mux = axil_data_t'(o_polarity);
			REG_WAIT_CNT:   rd_mux = axil_data_t'(o_wait_cnt);
			REG_AVG_SEL:    rd_mux = axil_data_t'(o_avg_sel);
			REG_GAIN_STEP:  rd_mux = axil_data_t'(o_gain_step);
			REG_CONST_STEP: rd_mux = axil_data_t'(o_const_step);
			REG_FB_ON:      rd_mux = axil_data_t'(o_fb_on);
			REG_GAIN_RAMP:  rd_mux = axil_data_t'(o_gain_ramp);
			REG_ERR_OFFSET: rd_mux = axil_data_t'(o_err_offset);
			REG_ERR:        rd_mux = axil_data_t'(i_err);
			REG_STEP:       rd_mux = axil_data_t'(i_step);
			default:        rd_mux = '0;
		endcase
	end

	// read channel, data captured once at the address beat
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n)
			o_rvalid <= 1'b0;
		else if (ar_fire)
			o_rvalid <= 1'b1;
		else if (o_rvalid && i_rready)
			o_rvalid <= 1'b0;
	end

	always_ff @(posedge CLOCK_DAC_1) begin
		if (ar_fire)
			o_rdata <= rd_mux;
	end

	// write response held until the master takes it
	a_bvalid_hold: assert property (@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_bvalid && !i_bready |=> o_bvalid);

	// read beat frozen while stalled
	a_rdata_hold: assert property (@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

`default_nettype wire

// ==== source/fog_loop_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fog_loop_top (
	input  logic                   CLOCK_DAC_1,
	input  logic                   i_rst_n,
	input  regmap_pkg::axil_addr_t i_awaddr,
	input  logic                   i_awvalid,
	output logic                   o_awready,
	input  regmap_pkg::axil_data_t i_wdata,
	input  logic                   i_wvalid,
	output logic                   o_wready,
	output logic [1:0]             o_bresp,
	output logic                   o_bvalid,
	input  logic                   i_bready,
	input  regmap_pkg::axil_addr_t i_araddr,
	input  logic                   i_arvalid,
	output logic                   o_arready,
	output regmap_pkg::axil_data_t o_rdata,
	output logic [1:0]             o_rresp,
	output logic                   o_rvalid,
	input  logic                   i_rready,
	input  gyro_pkg::adc_t         i_adc,
	output gyro_pkg::dac_t         o_dac
);

	import gyro_pkg::*;

	// settings out of the register file
	cnt_t   freq_cnt;
	cnt_t   wait_cnt;
	data_t  amp_h;
	data_t  amp_l;
	data_t  const_step;
	data_t  err_offset;
	logic   polarity;
	logic   fb_on;
	shift_t avg_sel;
	shift_t gain_step;
	shift_t gain_ramp;

	// loop chain
	data_t  mod_out;
	logic   mod_high;
	logic   mod_trig;
	data_t  err;
	logic   err_valid;
	data_t  step;

	// host side, settings and readback
	axil_regs u_regs (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_awaddr     (i_awaddr),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_wdata      (i_wdata),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.o_bresp      (o_bresp),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.i_araddr     (i_araddr),
		.i_arvalid    (i_arvalid),
		.o_arready    (o_arready),
		.o_rdata      (o_rdata),
		.o_rresp      (o_rresp),
		.o_rvalid     (o_rvalid),
		.i_rready     (i_rready),
		.o_freq_cnt   (freq_cnt),
		.o_wait_cnt   (wait_cnt),
		.o_amp_h      (amp_h),
		.o_amp_l      (amp_l),
		.o_const_step (const_step),
		.o_err_offset (err_offset),
		.o_polarity   (polarity),
		.o_fb_on      (fb_on),
		.o_avg_sel    (avg_sel),
		.o_gain_step  (gain_step),
		.o_gain_ramp  (gain_ramp),
		.i_err        (err),
		.i_step       (step)
	);

	// square-wave bias modulation
	mod_gen u_mod_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_freq_cnt  (freq_cnt),
		.i_amp_h     (amp_h),
		.i_amp_l     (amp_l),
		.o_mod_out   (mod_out),
		.o_mod_high  (mod_high),
		.o_mod_trig  (mod_trig)
	);

	// rate error from the two half averages
	err_demod u_err_demod (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_mod_high   (mod_high),
		.i_mod_trig   (mod_trig),
		.i_adc        (i_adc),
		.i_wait_cnt   (wait_cnt),
		.i_avg_sel    (avg_sel),
		.i_polarity   (polarity),
		.i_err_offset (err_offset),
		.o_err        (err),
		.o_err_valid  (err_valid)
	);

	// loop integrator
	fb_step_gen u_fb_step_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_err        (err),
		.i_err_valid  (err_valid),
		.i_fb_on      (fb_on),
		.i_gain_step  (gain_step),
		.i_const_step (const_step),
		.o_step       (step)
	);

	// serrodyne ramp plus modulation into the dac
	phase_ramp_gen u_phase_ramp_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n     (i_rst_n),
		.i_step      (step),
		.i_mod_out   (mod_out),
		.i_mod_trig  (mod_trig),
		.i_gain_ramp (gain_ramp),
		.o_dac       (o_dac)
	);

endmodule

`default_nettype wire
